// ==== design/dnc_write_pkg.sv ====
package dnc_write_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int W_SIZE    = 4;
  localparam int L_SIZE    = 4;
  // k, e, v rows plus beta, ga, gw
  localparam int NUM_ROWS  = 3 * W_SIZE + 3;
  localparam int NUM_PAIRS = NUM_ROWS * L_SIZE;

  // Widths
  localparam int OPD_W  = 16;
  localparam int ACC_W  = 32;
  localparam int ROW_W  = 4;
  localparam int COL_W  = 2;
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // Scalar rows after the three W-row blocks
  localparam logic [ROW_W-1:0] ROW_BETA = ROW_W'(12);
  localparam logic [ROW_W-1:0] ROW_GA   = ROW_W'(13);
  localparam logic [ROW_W-1:0] ROW_GW   = ROW_W'(14);
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(L_SIZE - 1);

  //////////////////////////////////////////////////////////////////////
  // Address map, byte addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] ADDR_WEIGHT_BASE = 12'h000;
  localparam logic [ADDR_W-1:0] ADDR_HIDDEN_BASE = 12'h100;
  localparam logic [ADDR_W-1:0] ADDR_CTRL        = 12'h200;
  localparam logic [ADDR_W-1:0] ADDR_STATUS      = 12'h204;
  localparam logic [ADDR_W-1:0] ADDR_RESULT_BASE = 12'h300;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // Pipeline structs
  //////////////////////////////////////////////////////////////////////

  // One operand pair
  typedef struct packed {
    logic                    valid;
    logic [ROW_W-1:0]        row;
    logic                    first;
    logic                    last;
    logic signed [OPD_W-1:0] weight;
    logic signed [OPD_W-1:0] hidden;
  } mac_op_t;

  typedef struct packed {
    logic                    valid;
    logic [ROW_W-1:0]        row;
    logic                    first;
    logic                    last;
    logic signed [ACC_W-1:0] product;
  } mac_prod_t;

  typedef struct packed {
    logic             valid;
    logic [ROW_W-1:0] row;
    logic [ACC_W-1:0] value;
  } mac_result_t;

endpackage

// ==== design/dnc_axil_regs.sv ====
`timescale 1ns/1ns

module dnc_axil_regs (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  dnc_write_pkg::axil_req_t               axil_req,
  output dnc_write_pkg::axil_rsp_t               axil_rsp,
  output logic                                   start,
  output logic signed [dnc_write_pkg::OPD_W-1:0] weights [dnc_write_pkg::NUM_PAIRS],
  output logic signed [dnc_write_pkg::OPD_W-1:0] hidden [dnc_write_pkg::L_SIZE],
  input  dnc_write_pkg::mac_result_t             result
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic busy;
  logic done;
  logic [dnc_write_pkg::ACC_W-1:0] result_q [dnc_write_pkg::NUM_ROWS];

  // Write side decode
  logic       wr_fire;
  logic       wr_weight;
  logic       wr_hidden;
  logic       wr_ctrl;
  logic       wr_start;
  int         wr_idx;
  logic [1:0] wr_resp;

  // Read side decode
  logic                             rd_fire;
  logic [dnc_write_pkg::DATA_W-1:0] rd_data;
  logic [1:0]                       rd_resp;

  // True when addr falls inside a block of words starting at base
  function automatic logic in_space(input logic [dnc_write_pkg::ADDR_W-1:0] addr,
                                    input logic [dnc_write_pkg::ADDR_W-1:0] base,
                                    input int words);
    int offs;
    offs = int'(addr) - int'(base);
    return (offs >= 0) && (offs < 4 * words);
  endfunction

  function automatic int word_idx(input logic [dnc_write_pkg::ADDR_W-1:0] addr,
                                  input logic [dnc_write_pkg::ADDR_W-1:0] base);
    return (int'(addr) - int'(base)) >>> 2;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_fire   = axil_rsp.awready && axil_req.awvalid && axil_req.wvalid;
    wr_weight = in_space(axil_req.awaddr, dnc_write_pkg::ADDR_WEIGHT_BASE,
                         dnc_write_pkg::NUM_PAIRS);
    wr_hidden = in_space(axil_req.awaddr, dnc_write_pkg::ADDR_HIDDEN_BASE,
                         dnc_write_pkg::L_SIZE);
    wr_ctrl   = (axil_req.awaddr == dnc_write_pkg::ADDR_CTRL);
    wr_idx    = word_idx(axil_req.awaddr, wr_hidden ? dnc_write_pkg::ADDR_HIDDEN_BASE
                                                    : dnc_write_pkg::ADDR_WEIGHT_BASE);
    // Start only from idle, a busy start is dropped silently
    wr_start  = wr_fire && wr_ctrl && axil_req.wdata[0] && !busy;
    // Operand writes locked out during a run
    if (wr_weight || wr_hidden) begin
      wr_resp = busy ? dnc_write_pkg::RESP_SLVERR : dnc_write_pkg::RESP_OKAY;
    end else if (wr_ctrl) begin
      wr_resp = dnc_write_pkg::RESP_OKAY;
    end else begin
      // Status and results are read-only
      wr_resp = dnc_write_pkg::RESP_DECERR;
    end
  end

  always_comb begin
    rd_fire = axil_rsp.arready && axil_req.arvalid;
    rd_data = '0;
    rd_resp = dnc_write_pkg::RESP_OKAY;
    if (in_space(axil_req.araddr, dnc_write_pkg::ADDR_WEIGHT_BASE,
                 dnc_write_pkg::NUM_PAIRS)) begin
      // Signed element, so the word is sign-extended
      rd_data = weights[word_idx(axil_req.araddr, dnc_write_pkg::ADDR_WEIGHT_BASE)];
    end else if (in_space(axil_req.araddr, dnc_write_pkg::ADDR_HIDDEN_BASE,
                          dnc_write_pkg::L_SIZE)) begin
      rd_data = hidden[word_idx(axil_req.araddr, dnc_write_pkg::ADDR_HIDDEN_BASE)];
    end else if (in_space(axil_req.araddr, dnc_write_pkg::ADDR_RESULT_BASE,
                          dnc_write_pkg::NUM_ROWS)) begin
      rd_data = result_q[word_idx(axil_req.araddr, dnc_write_pkg::ADDR_RESULT_BASE)];
    end else if (axil_req.araddr == dnc_write_pkg::ADDR_STATUS) begin
      rd_data[1:0] = {done, busy};
    end else if (axil_req.araddr != dnc_write_pkg::ADDR_CTRL) begin
      rd_resp = dnc_write_pkg::RESP_DECERR;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      axil_rsp <= '0;
      start    <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
      for (int i = 0; i < dnc_write_pkg::NUM_PAIRS; i++) weights[i] <= '0;
      for (int i = 0; i < dnc_write_pkg::L_SIZE; i++) hidden[i] <= '0;
      for (int i = 0; i < dnc_write_pkg::NUM_ROWS; i++) result_q[i] <= '0;
    end else begin
      // One-cycle accept pulse, held off while a response waits
      axil_rsp.awready <= axil_req.awvalid && axil_req.wvalid &&
                          !axil_rsp.bvalid && !axil_rsp.awready;
      axil_rsp.wready  <= axil_req.awvalid && axil_req.wvalid &&
                          !axil_rsp.bvalid && !axil_rsp.awready;
      if (wr_fire) begin
        axil_rsp.bvalid <= 1'b1;
        axil_rsp.bresp  <= wr_resp;
      end else if (axil_req.bready) begin
        axil_rsp.bvalid <= 1'b0;
      end

      if (wr_fire && wr_weight && !busy) begin
        weights[wr_idx] <= axil_req.wdata[dnc_write_pkg::OPD_W-1:0];
      end
      if (wr_fire && wr_hidden && !busy) begin
        hidden[wr_idx] <= axil_req.wdata[dnc_write_pkg::OPD_W-1:0];
      end

      // Read channel, same pulse scheme
      axil_rsp.arready <= axil_req.arvalid && !axil_rsp.rvalid && !axil_rsp.arready;
      if (rd_fire) begin
        axil_rsp.rvalid <= 1'b1;
        axil_rsp.rdata  <= rd_data;
        axil_rsp.rresp  <= rd_resp;
      end else if (axil_req.rready) begin
        axil_rsp.rvalid <= 1'b0;
      end

      // Run control
      start <= wr_start;
      if (wr_start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (result.valid && result.row == dnc_write_pkg::ROW_GW) begin
        busy <= 1'b0;
        done <= 1'b1;
      end

      if (result.valid) begin
        result_q[result.row] <= result.value;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Write response held until taken
  assert property (@(posedge CLK) disable iff (RST)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

  // Pipeline output only inside a run
  assert property (@(posedge CLK) disable iff (RST)
    result.valid |-> busy);

endmodule

// ==== design/dnc_row_sequencer.sv ====
`timescale 1ns/1ns

module dnc_row_sequencer (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   start,
  input  logic signed [dnc_write_pkg::OPD_W-1:0] weights [dnc_write_pkg::NUM_PAIRS],
  input  logic signed [dnc_write_pkg::OPD_W-1:0] hidden [dnc_write_pkg::L_SIZE],
  output dnc_write_pkg::mac_op_t                 op
);

  logic                            active;
  logic [dnc_write_pkg::ROW_W-1:0] row_q;
  logic [dnc_write_pkg::COL_W-1:0] col_q;
  // Flat weight index, L_SIZE fills the column field exactly
  logic [dnc_write_pkg::ROW_W+dnc_write_pkg::COL_W-1:0] pair_idx;

  //////////////////////////////////////////////////////////////////////
  // Row and column walk
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active <= 1'b0;
      row_q  <= '0;
      col_q  <= '0;
    end else if (start) begin
      active <= 1'b1;
      row_q  <= '0;
      col_q  <= '0;
    end else if (active) begin
      if (col_q == dnc_write_pkg::LAST_COL) begin
        col_q <= '0;
        // gw is the final row of the run
        if (row_q == dnc_write_pkg::ROW_GW) begin
          active <= 1'b0;
          row_q  <= '0;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////////////////////////

  assign pair_idx = {row_q, col_q};

  always_comb begin
    op.valid  = active;
    op.row    = row_q;
    op.first  = (col_q == '0);
    op.last   = (col_q == dnc_write_pkg::LAST_COL);
    op.weight = weights[pair_idx];
    op.hidden = hidden[col_q];
  end

  // Register block must keep starts out of a running walk
  assert property (@(posedge CLK) disable iff (RST)
    start |-> !active);

endmodule

// ==== design/dnc_mac_stage.sv ====
`timescale 1ns/1ns

module dnc_mac_stage (
  input  logic                       CLK,
  input  logic                       RST,
  input  dnc_write_pkg::mac_op_t     op,
  output dnc_write_pkg::mac_result_t result
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  dnc_write_pkg::mac_prod_t prod_q;

  // Running sum of the current row
  logic signed [dnc_write_pkg::ACC_W-1:0] acc_q;
  logic signed [dnc_write_pkg::ACC_W-1:0] acc_next;

  //////////////////////////////////////////////////////////////////////
  // Multiply stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_q <= '0;
    end else begin
      prod_q.valid   <= op.valid;
      prod_q.row     <= op.row;
      prod_q.first   <= op.first;
      prod_q.last    <= op.last;
      // Both operands signed, extended to ACC_W before the multiply
      prod_q.product <= op.weight * op.hidden;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulate stage
  //////////////////////////////////////////////////////////////////////

  // Load on first column, else add, wraps at ACC_W
  always_comb begin
    if (prod_q.first) begin
      acc_next = prod_q.product;
    end else begin
      acc_next = acc_q + prod_q.product;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc_q  <= '0;
      result <= '0;
    end else begin
      if (prod_q.valid) begin
        acc_q <= acc_next;
      end
      // Row finished on last, next row may load right behind it
      result.valid <= prod_q.valid && prod_q.last;
      result.row   <= prod_q.row;
      result.value <= acc_next;
    end
  end

  // No row switch mid-row
  assert property (@(posedge CLK) disable iff (RST)
    prod_q.valid && !prod_q.last |=> prod_q.valid && prod_q.row == $past(prod_q.row));

endmodule

// ==== design/dnc_write_interface_vector.sv ====
`timescale 1ns/1ns

module dnc_write_interface_vector (
  input  logic                     CLK,
  input  logic                     RST,
  input  dnc_write_pkg::axil_req_t axil_req,
  output dnc_write_pkg::axil_rsp_t axil_rsp
);

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////

  logic start;
  logic signed [dnc_write_pkg::OPD_W-1:0] weights [dnc_write_pkg::NUM_PAIRS];
  logic signed [dnc_write_pkg::OPD_W-1:0] hidden [dnc_write_pkg::L_SIZE];

  dnc_write_pkg::mac_op_t     op;
  dnc_write_pkg::mac_result_t result;

  // Host registers, run control and result store
  dnc_axil_regs u_regs (
    .CLK      (CLK),
    .RST      (RST),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .start    (start),
    .weights  (weights),
    .hidden   (hidden),
    .result   (result)
  );

  // Issue stage, one pair per cycle
  dnc_row_sequencer u_seq (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .weights (weights),
    .hidden  (hidden),
    .op      (op)
  );

  // Multiply then accumulate
  dnc_mac_stage u_mac (
    .CLK    (CLK),
    .RST    (RST),
    .op     (op),
    .result (result)
  );

endmodule

// ==== dv/dnc_axil_host.svh ====
`ifndef DNC_AXIL_HOST_SVH
`define DNC_AXIL_HOST_SVH

//////////////////////////////////////////////////////////////////////
// AXI4-Lite host tasks, included inside the testbench module
//////////////////////////////////////////////////////////////////////

// Full-word write, bready held low for hold cycles once bvalid is up
task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                          input int hold, output logic [1:0] resp);
  int n;
  @(posedge CLK);
  axil_req.awvalid <= 1'b1;
  axil_req.awaddr  <= addr;
  axil_req.wvalid  <= 1'b1;
  axil_req.wdata   <= data;
  axil_req.bready  <= (hold == 0);
  // Address and data are taken in the same cycle
  n = 0;
  do begin
    @(posedge CLK);
    n++;
  end while (!axil_rsp.awready && n < 16);
  axil_req.awvalid <= 1'b0;
  axil_req.wvalid  <= 1'b0;
  assert (axil_rsp.awready && axil_rsp.wready) else begin
    $display("%0t ns: write to %h was never accepted", $time, addr);
    err_count++;
  end
  n = 0;
  do begin
    @(posedge CLK);
    n++;
  end while (!axil_rsp.bvalid && n < 16);
  assert (axil_rsp.bvalid) else begin
    $display("%0t ns: no write response for %h", $time, addr);
    err_count++;
  end
  resp = axil_rsp.bresp;
  // Stalled response must not move
  repeat (hold) begin
    @(posedge CLK);
    assert (axil_rsp.bvalid) else begin
      $display("%0t ns: write response dropped while bready was low", $time);
      err_count++;
    end
    check_equal("bresp", 32'(resp), 32'(axil_rsp.bresp));
  end
  if (hold > 0) begin
    axil_req.bready <= 1'b1;
    @(posedge CLK);
  end
  axil_req.bready <= 1'b0;
endtask

// Read, rready held low for hold cycles once rvalid is up
task automatic axil_read(input logic [11:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
  int n;
  @(posedge CLK);
  axil_req.arvalid <= 1'b1;
  axil_req.araddr  <= addr;
  axil_req.rready  <= (hold == 0);
  n = 0;
  do begin
    @(posedge CLK);
    n++;
  end while (!axil_rsp.arready && n < 16);
  axil_req.arvalid <= 1'b0;
  assert (axil_rsp.arready) else begin
    $display("%0t ns: read of %h was never accepted", $time, addr);
    err_count++;
  end
  n = 0;
  do begin
    @(posedge CLK);
    n++;
  end while (!axil_rsp.rvalid && n < 16);
  assert (axil_rsp.rvalid) else begin
    $display("%0t ns: no read response for %h", $time, addr);
    err_count++;
  end
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  repeat (hold) begin
    @(posedge CLK);
    assert (axil_rsp.rvalid) else begin
      $display("%0t ns: read response dropped while rready was low", $time);
      err_count++;
    end
    check_equal("rdata", data, axil_rsp.rdata);
    check_equal("rresp", 32'(resp), 32'(axil_rsp.rresp));
  end
  if (hold > 0) begin
    axil_req.rready <= 1'b1;
    @(posedge CLK);
  end
  axil_req.rready <= 1'b0;
endtask

`endif

// ==== dv/dnc_write_tb.sv ====
`timescale 1ns/1ns

module dnc_write_tb;

  //////////////////////////////////////////////////////////////////////
  // Clock, reset, bus and counters
  //////////////////////////////////////////////////////////////////////

  logic CLK;
  logic RST;
  dnc_write_pkg::axil_req_t axil_req;
  dnc_write_pkg::axil_rsp_t axil_rsp;

  int err_count;
  int check_count;

  // Seed offset then h with h[3] first then response stall length
  typedef struct packed {
    logic [31:0] seed_offs;
    logic [dnc_write_pkg::L_SIZE-1:0][dnc_write_pkg::OPD_W-1:0] h;
    logic [7:0]  stall;
  } case_t;

  case_t cases [4] = '{
    '{32'h0000_0000, {16'h0004, 16'h0003, 16'hfffe, 16'h0001}, 8'd0},
    '{32'h1357_9bdf, {16'h7fff, 16'h8000, 16'h0123, 16'hff00}, 8'd2},
    '{32'h0f0f_0f0f, {16'hffff, 16'hfffe, 16'hfffd, 16'hfffc}, 8'd5},
    // All -32768 to push sums past 32 bits
    '{32'h8000_0001, {16'h8000, 16'h8000, 16'h8000, 16'h8000}, 8'd1}
  };

  // Weights of the case in flight
  logic [dnc_write_pkg::OPD_W-1:0] w_cur [dnc_write_pkg::NUM_PAIRS];

  dnc_write_interface_vector DUT (
    .CLK      (CLK),
    .RST      (RST),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic check_equal(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    check_count++;
    assert (got === exp) else begin
      $display("FAIL %0t ns %s expected %h read %h", $time, name, exp, got);
      err_count++;
    end
  endtask

  `include "dnc_axil_host.svh"

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] x);
    return 32'(signed'(x));
  endfunction

  // Row r of the weights against h with 32-bit wrap
  function automatic logic [31:0] dot_row(input int r,
      input logic [dnc_write_pkg::L_SIZE-1:0][dnc_write_pkg::OPD_W-1:0] h);
    logic signed [31:0] acc;
    acc = 0;
    for (int l = 0; l < dnc_write_pkg::L_SIZE; l++) begin
      acc += sext16(w_cur[r * dnc_write_pkg::L_SIZE + l]) * sext16(h[l]);
    end
    return acc;
  endfunction

  // k, e, v blocks then the three scalars
  function automatic string row_name(input int r);
    if (r < 3 * dnc_write_pkg::W_SIZE) begin
      return $sformatf("%s[%0d]", (r < 4) ? "k" : (r < 8) ? "e" : "v", r % 4);
    end
    return (r == 12) ? "beta" : (r == 13) ? "ga" : "gw";
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] state;
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          errs_before;
    int          polls;
    CLK         = 1'b0;
    RST         = 1'b1;
    axil_req    = '0;
    err_count   = 0;
    check_count = 0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;

    foreach (cases[i]) begin
      errs_before = err_count;
      state = 32'hfb49_5305 ^ cases[i].seed_offs;
      // Weights with the first write stalling its response
      for (int p = 0; p < dnc_write_pkg::NUM_PAIRS; p++) begin
        state    = xorshift32(state);
        w_cur[p] = state[15:0];
        axil_write(12'(dnc_write_pkg::ADDR_WEIGHT_BASE + 4 * p), sext16(w_cur[p]),
                   (p == 0) ? int'(cases[i].stall) : 0, resp);
        check_equal("bresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
      end
      for (int l = 0; l < dnc_write_pkg::L_SIZE; l++) begin
        axil_write(12'(dnc_write_pkg::ADDR_HIDDEN_BASE + 4 * l), sext16(cases[i].h[l]),
                   0, resp);
        check_equal("bresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
      end

      // Start and expect busy while running
      axil_write(dnc_write_pkg::ADDR_CTRL, 32'h1, 0, resp);
      check_equal("bresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
      axil_read(dnc_write_pkg::ADDR_STATUS, 0, rdata, resp);
      check_equal("status", 32'h1, rdata);
      // Refused write to a gw weight the run has not reached yet
      axil_write(12'(dnc_write_pkg::ADDR_WEIGHT_BASE + 4 * (dnc_write_pkg::NUM_PAIRS - 1)),
                 ~sext16(w_cur[dnc_write_pkg::NUM_PAIRS - 1]), 0, resp);
      check_equal("bresp", 32'(dnc_write_pkg::RESP_SLVERR), 32'(resp));

      polls = 0;
      do begin
        axil_read(dnc_write_pkg::ADDR_STATUS, 0, rdata, resp);
        polls++;
      end while (!rdata[1] && polls < 40);
      assert (rdata[1]) else begin
        $display("%0t ns: busy flag stuck, case %0d never finished", $time, i);
        err_count++;
      end
      check_equal("status", 32'h2, rdata);

      // Results with the first read stalling its response
      for (int r = 0; r < dnc_write_pkg::NUM_ROWS; r++) begin
        axil_read(12'(dnc_write_pkg::ADDR_RESULT_BASE + 4 * r),
                  (r == 0) ? int'(cases[i].stall) : 0, rdata, resp);
        check_equal("rresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
        check_equal(row_name(r), dot_row(r, cases[i].h), rdata);
      end

      // Sign-extended readback
      axil_read(dnc_write_pkg::ADDR_WEIGHT_BASE, 0, rdata, resp);
      check_equal("weight[0]", sext16(w_cur[0]), rdata);
      check_equal("rresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
      axil_read(12'(dnc_write_pkg::ADDR_WEIGHT_BASE + 4 * (dnc_write_pkg::NUM_PAIRS - 1)),
                0, rdata, resp);
      check_equal("weight[59]", sext16(w_cur[dnc_write_pkg::NUM_PAIRS - 1]), rdata);
      check_equal("rresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));
      axil_read(12'(dnc_write_pkg::ADDR_HIDDEN_BASE + 4 * (i % 4)), 0, rdata, resp);
      check_equal("hidden", sext16(cases[i].h[i % 4]), rdata);
      check_equal("rresp", 32'(dnc_write_pkg::RESP_OKAY), 32'(resp));

      // Unmapped read and a write to the read-only result space
      axil_read(12'h400, 0, rdata, resp);
      check_equal("rresp", 32'(dnc_write_pkg::RESP_DECERR), 32'(resp));
      axil_write(12'(dnc_write_pkg::ADDR_RESULT_BASE + 4 * i), 32'hdead_beef, 0, resp);
      check_equal("bresp", 32'(dnc_write_pkg::RESP_DECERR), 32'(resp));

      $display("Test %0d finished with %0d errors", i, err_count - errs_before);
    end

    $display("Checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog sized from per-case bus traffic
  initial begin
    int unsigned limit;
    limit = $size(cases) * ((dnc_write_pkg::NUM_PAIRS + dnc_write_pkg::L_SIZE) * 4 + 80 +
            dnc_write_pkg::NUM_ROWS * 4) + 200;
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, run did not complete", limit);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+dv
design/dnc_write_pkg.sv
design/dnc_axil_regs.sv
design/dnc_row_sequencer.sv
design/dnc_mac_stage.sv
design/dnc_write_interface_vector.sv
dv/dnc_write_tb.sv

// ==== Makefile ====
# Verilator build and run of the DNC write-interface testbench

VERILATOR ?= verilator
TOP       ?= dnc_write_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || { echo "Simulation reported errors"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
